/* dv/img_display_props.sv */
`timescale 1ns/100ps
`include "img_params.svh"

module img_display_props (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              i_op_valid,
    input img_pkg::op_mode_t i_op_mode,
    input logic              o_op_ready,
    input logic              o_in_ready,
    input logic              o_out_valid,
    input img_pkg::result_t  o_out_data
);
    import img_pkg::*;

    logic load_run;   // a LOAD op is in flight

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_run <= 1'b0;
        end else if (i_op_valid && i_op_mode == OP_LOAD) begin
            load_run <= 1'b1;
        end else if (o_op_ready) begin
            load_run <= 1'b0;            // ready ends any op
        end
    end

    // --------------------
    // port rules
    // --------------------
    ap_ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_op_ready |=> !o_op_ready)
        else $error("o_op_ready high for two cycles in a row");

    ap_ready_vs_out: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_op_ready && o_out_valid))
        else $error("o_op_ready and o_out_valid high together");

    ap_zero_ext: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_out_valid |-> (o_out_data[`OUT_W-1:`PIX_W] == '0))
        else $error("upper output bits not zero");

    ap_in_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !load_run |-> !o_in_ready)
        else $error("o_in_ready high with no load running");

endmodule

bind img_display_core img_display_props u_props (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_op_valid  (i_op_valid),
    .i_op_mode   (i_op_mode),
    .o_op_ready  (o_op_ready),
    .o_in_ready  (o_in_ready),
    .o_out_valid (o_out_valid),
    .o_out_data  (o_out_data)
);

/* dv/img_display_tb.sv */
`timescale 1ns/100ps
`include "img_params.svh"

module img_display_tb;
    import img_pkg::*;

    // one table row, expected values hold after the last repeat
    typedef struct packed {
        int op;
        int gaps;
        int reps;
        int ox;
        int oy;
        int depth;
        int count;
    } row_t;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_op_valid;
    op_mode_t   i_op_mode;
    logic       i_in_valid;
    pixel_t     i_in_data;
    logic       o_op_ready;
    logic       o_in_ready;
    logic       o_out_valid;
    result_t    o_out_data;

    pixel_t     image [`IMG_PIX];   // reference copy of the loaded image
    row_t       rows [$];
    logic       table_ready = 1'b0;
    int         seed = 58;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;

    img_display_core dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;   // 8 ns period
    end

    // --------------------
    // helpers
    // --------------------
    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    function automatic void add_row(input int op, gaps, reps, ox, oy, depth, count);
        rows.push_back('{op, gaps, reps, ox, oy, depth, count});
    endfunction

    // channel outer, then (0,0) (1,0) (0,1) (1,1)
    function automatic int window_pixel(input int k, input int ox, input int oy);
        int ch;
        int x;
        int y;
        ch = k / 4;
        x  = ox + (k % 4) % 2;
        y  = oy + (k % 4) / 2;
        return int'(image[ch * `IMG_W * `IMG_H + y * `IMG_W + x]);
    endfunction

    function automatic int depth_chans(input depth_sel_t d);
        case (d)
            DEPTH_8:  return 8;
            DEPTH_16: return 16;
            default:  return 32;
        endcase
    endfunction

    // sampled edges from the accepted op to the ready pulse
    function automatic int ready_latency(input int op, input int depth);
        if (op == OP_LOAD) return 1;                 // counted from the last pixel
        if (op == OP_DISPLAY) return 4 * depth + 3;  // start, first read, words, done
        return 2;
    endfunction

    function automatic int worst_cycles();
        int total;
        total = 16;                                        // reset and boot
        foreach (rows[i]) begin
            if (rows[i].op == OP_LOAD) begin
                total += rows[i].reps * (2 * `IMG_PIX + 8);   // at most one gap per pixel
            end else if (rows[i].op == OP_DISPLAY) begin
                total += rows[i].reps * (4 * `IMG_C + 8);
            end else begin
                total += rows[i].reps * 8;
            end
        end
        return total;
    endfunction

    task automatic build_table();
        //      opcode      gaps reps  x  y depth outputs
        add_row(OP_LOAD,    0,   1,    0, 0, 32,     0);
        add_row(OP_DISPLAY, 0,   1,    0, 0, 32,   128);
        add_row(OP_ORG_R,   0,   1,    1, 0, 32,     0);
        add_row(OP_ORG_D,   0,   1,    1, 1, 32,     0);
        add_row(OP_LOAD,    1,   1,    1, 1, 32,     0);
        add_row(OP_DISPLAY, 0,   1,    1, 1, 32,   128);
        add_row(OP_ORG_R,   0,   7,    6, 1, 32,     0);   // saturates at 6
        add_row(OP_ORG_D,   0,   7,    6, 6, 32,     0);
        add_row(OP_DISPLAY, 0,   1,    6, 6, 32,   128);
        add_row(OP_ORG_L,   0,   7,    0, 6, 32,     0);   // last one sits at 0
        add_row(OP_ORG_U,   0,   7,    0, 0, 32,     0);
        add_row(OP_DISPLAY, 0,   1,    0, 0, 32,   128);
        add_row(OP_SCALE_D, 0,   3,    0, 0,  8,     0);
        add_row(OP_DISPLAY, 0,   1,    0, 0,  8,    32);
        add_row(OP_SCALE_U, 0,   1,    0, 0, 16,     0);
        add_row(OP_DISPLAY, 0,   1,    0, 0, 16,    64);
        add_row(OP_SCALE_U, 0,   1,    0, 0, 32,     0);
        add_row(OP_DISPLAY, 0,   1,    0, 0, 32,   128);
        add_row(OP_SCALE_U, 0,   1,    0, 0, 32,     0);   // no growth past 32
        add_row(OP_DISPLAY, 0,   1,    0, 0, 32,   128);
        add_row(OP_ORG_R,   0,   3,    3, 0, 32,     0);
        add_row(OP_ORG_D,   0,   2,    3, 2, 32,     0);
        add_row(OP_SCALE_D, 0,   1,    3, 2, 16,     0);
        add_row(8,          0,   8,    3, 2, 16,     0);   // opcodes 8..15
        add_row(OP_DISPLAY, 0,   1,    3, 2, 16,    64);
    endtask

    // new image into the model, then stream it in
    task automatic load_image(input int gaps);
        int waits;
        waits = 0;
        foreach (image[i]) image[i] = pixel_t'($random(seed));
        do begin
            @(posedge i_clk);
            waits++;
        end while (!o_in_ready);
        check_value("o_in_ready latency", waits, 1);      // up the cycle after the op
        for (int i = 0; i < `IMG_PIX; i++) begin
            if (gaps != 0 && (($random(seed) & 3) == 0)) begin
                i_in_valid <= 1'b0;                        // one idle cycle
                @(posedge i_clk);
            end
            i_in_valid <= 1'b1;
            i_in_data  <= image[i];
            @(posedge i_clk);
            check_value("o_in_ready", int'(o_in_ready), 1);   // held through the load
        end
        i_in_valid <= 1'b0;
    endtask

    // issue one op, then gather outputs until the ready pulse
    task automatic run_op(input int op, input int gaps, input int ox, input int oy,
                          input int depth, inout int outs);
        int cycles;
        cycles = 0;
        i_op_valid <= 1'b1;
        i_op_mode  <= op_mode_t'(op);
        @(posedge i_clk);
        i_op_valid <= 1'b0;
        if (op == OP_LOAD) load_image(gaps);
        do begin
            @(posedge i_clk);
            cycles++;
            if (o_out_valid) begin
                if (outs < 4 * `IMG_C) begin
                    check_value("o_out_data", int'(o_out_data), window_pixel(outs, ox, oy));
                end
                outs++;
            end
        end while (!o_op_ready);
        check_value("o_op_ready latency", cycles, ready_latency(op, depth));
        if (op == OP_LOAD) begin
            check_value("o_in_ready", int'(o_in_ready), 0);   // drops with the ready pulse
        end
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 2 * worst_cycles();
        repeat (limit) @(posedge i_clk);
        $display("timeout after %0d cycles, the DUT stopped answering", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        row_t row;
        int   outs;
        int   op;
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = OP_LOAD;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        do begin
            @(posedge i_clk);
        end while (!o_op_ready);                           // first ready after reset
        foreach (rows[t]) begin
            row  = rows[t];
            outs = 0;
            for (int r = 0; r < row.reps; r++) begin
                op = (row.op >= 8) ? row.op + r : row.op;  // undefined ops walk upward
                run_op(op, row.gaps, row.ox, row.oy, row.depth, outs);
            end
            check_value("output count", outs, row.count);
            check_value("origin_x", int'(dut.u_cfg.o_origin_x), row.ox);
            check_value("origin_y", int'(dut.u_cfg.o_origin_y), row.oy);
            check_value("depth", depth_chans(dut.u_cfg.o_depth_sel), row.depth);
            tests++;
            $display("test %0d op %0d x%0d: %0d outputs, %0d errors so far",
                     t, row.op, row.reps, outs, errors);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/img_pkg.sv
verilog/img_mem_bank.sv
verilog/img_banked_mem.sv
verilog/view_config_regs.sv
verilog/op_sequencer.sv
verilog/display_streamer.sv
verilog/img_display_core.sv
dv/img_display_props.sv
dv/img_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the image display core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=img_display_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module img_display_tb \
    --Mdir "${BUILD_DIR}" -o "${SIM_EXE}" \
    -f files.f
status=$?
if [ ${status} -ne 0 ]; then
    echo "verilator compile failed with status ${status}"
    exit 1
fi

"./${BUILD_DIR}/${SIM_EXE}" > "${LOG_FILE}" 2>&1
status=$?
cat "${LOG_FILE}"
if [ ${status} -ne 0 ]; then
    echo "simulation exited with status ${status}"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "${LOG_FILE}"; then
    exit 0
fi
echo "pass line not found in ${LOG_FILE}"
exit 1

/* verilog/display_streamer.sv */
`timescale 1ns/100ps
`include "img_params.svh"

module display_streamer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_disp_start,
    input  img_pkg::coord_t     i_origin_x,
    input  img_pkg::coord_t     i_origin_y,
    input  img_pkg::depth_sel_t i_depth_sel,
    input  img_pkg::pixel_t     i_rd_data,    // one cycle after o_rd_en
    output logic                o_rd_en,
    output img_pkg::pix_index_t o_rd_index,
    output logic                o_out_valid,
    output img_pkg::result_t    o_out_data,
    output logic                o_disp_done
);
    import img_pkg::*;

    logic   active;        // issuing reads
    chan_t  chan_cnt;      // outer loop
    logic   [1:0] pos_cnt; // 0:(0,0) 1:(1,0) 2:(0,1) 3:(1,1)
    coord_t rd_x;
    coord_t rd_y;

    // last channel for the selected depth
    function automatic chan_t last_chan(input depth_sel_t dsel);
        case (dsel)
            DEPTH_8:  return chan_t'(7);
            DEPTH_16: return chan_t'(15);
            default:  return chan_t'(31);
        endcase
    endfunction

    // --------------------
    // read address generation
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active   <= 1'b0;
            chan_cnt <= '0;
            pos_cnt  <= '0;
        end else if (i_disp_start) begin
            active   <= 1'b1;
            chan_cnt <= '0;
            pos_cnt  <= '0;
        end else if (active) begin
            pos_cnt <= pos_cnt + 2'd1;                 // wraps after (1,1)
            if (pos_cnt == 2'd3) begin
                if (chan_cnt == last_chan(i_depth_sel)) begin
                    active <= 1'b0;
                end else begin
                    chan_cnt <= chan_cnt + 1'b1;
                end
            end
        end
    end

    assign rd_x       = i_origin_x + coord_t'(pos_cnt[0]);   // origin <= 6, no wrap
    assign rd_y       = i_origin_y + coord_t'(pos_cnt[1]);
    assign o_rd_en    = active;
    assign o_rd_index = {chan_cnt, rd_y, rd_x};

    // --------------------
    // output stage
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
            o_disp_done <= 1'b0;
        end else begin
            o_out_valid <= active;                     // tracks memory latency
            o_disp_done <= o_out_valid && !active;     // cycle after last word
        end
    end

    // zero-extend, held at 0 between words
    assign o_out_data = o_out_valid ?
                        result_t'({{(`OUT_W - `PIX_W){1'b0}}, i_rd_data}) : '0;

endmodule

/* verilog/img_banked_mem.sv */
`timescale 1ns/100ps
`include "img_params.svh"

module img_banked_mem (
    input  logic                i_clk,
    input  logic                i_wr_en,
    input  img_pkg::pix_index_t i_wr_index,
    input  img_pkg::pixel_t     i_wr_data,
    input  logic                i_rd_en,
    input  img_pkg::pix_index_t i_rd_index,
    output img_pkg::pixel_t     o_rd_data
);
    import img_pkg::*;

    // index layout {chan, y, x}, bank = low chan bits
    localparam int XY_W   = 2 * $bits(coord_t);
    localparam int BANK_W = $bits(bank_sel_t);

    bank_sel_t  wr_bank;
    bank_sel_t  rd_bank;
    bank_sel_t  rd_bank_q;                    // bank read last cycle
    bank_addr_t wr_off;
    bank_addr_t rd_off;
    pixel_t     bank_rdata [`SRAM_COUNT];

    // --------------------
    // index to bank / offset
    // --------------------
    assign wr_bank = i_wr_index[XY_W +: BANK_W];
    assign rd_bank = i_rd_index[XY_W +: BANK_W];
    assign wr_off  = {i_wr_index[$bits(pix_index_t)-1 : XY_W+BANK_W], i_wr_index[XY_W-1:0]};
    assign rd_off  = {i_rd_index[$bits(pix_index_t)-1 : XY_W+BANK_W], i_rd_index[XY_W-1:0]};

    for (genvar b = 0; b < `SRAM_COUNT; b++) begin : g_bank
        logic wr_hit;
        logic rd_hit;

        assign wr_hit = i_wr_en && (wr_bank == bank_sel_t'(b));
        assign rd_hit = i_rd_en && (rd_bank == bank_sel_t'(b));

        img_mem_bank #(
            .ADDR_W (`SRAM_ADDR_W)
        ) u_bank (
            .i_clk   (i_clk),
            .i_en    (wr_hit || rd_hit),
            .i_we    (wr_hit),                    // load and display never overlap
            .i_addr  (wr_hit ? wr_off : rd_off),
            .i_wdata (i_wr_data),
            .o_rdata (bank_rdata[b])
        );
    end

    // remember which bank answers next cycle
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            rd_bank_q <= rd_bank;
        end
    end

    assign o_rd_data = bank_rdata[rd_bank_q];

endmodule

/* verilog/img_display_core.sv */
`timescale 1ns/100ps

module img_display_core (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_op_valid,
    input  img_pkg::op_mode_t i_op_mode,
    input  logic              i_in_valid,
    input  img_pkg::pixel_t   i_in_data,
    output logic              o_op_ready,
    output logic              o_in_ready,
    output logic              o_out_valid,
    output img_pkg::result_t  o_out_data
);
    import img_pkg::*;

    // --------------------
    // internal wires
    // --------------------
    logic       wr_en;
    pix_index_t wr_index;
    cfg_cmd_t   cfg_cmd;
    logic       disp_start;
    logic       disp_done;
    coord_t     origin_x;
    coord_t     origin_y;
    depth_sel_t depth_sel;
    logic       rd_en;
    pix_index_t rd_index;
    pixel_t     rd_data;

    op_sequencer u_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op_valid   (i_op_valid),
        .i_op_mode    (i_op_mode),
        .i_in_valid   (i_in_valid),
        .i_disp_done  (disp_done),
        .o_op_ready   (o_op_ready),
        .o_in_ready   (o_in_ready),
        .o_wr_en      (wr_en),
        .o_wr_index   (wr_index),
        .o_cfg_cmd    (cfg_cmd),
        .o_disp_start (disp_start)
    );

    view_config_regs u_cfg (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cfg_cmd   (cfg_cmd),
        .o_origin_x  (origin_x),
        .o_origin_y  (origin_y),
        .o_depth_sel (depth_sel)
    );

    display_streamer u_disp (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_disp_start (disp_start),
        .i_origin_x   (origin_x),
        .i_origin_y   (origin_y),
        .i_depth_sel  (depth_sel),
        .i_rd_data    (rd_data),
        .o_rd_en      (rd_en),
        .o_rd_index   (rd_index),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data),
        .o_disp_done  (disp_done)
    );

    img_banked_mem u_mem (
        .i_clk      (i_clk),
        .i_wr_en    (wr_en),
        .i_wr_index (wr_index),
        .i_wr_data  (i_in_data),   // load data goes straight in
        .i_rd_en    (rd_en),
        .i_rd_index (rd_index),
        .o_rd_data  (rd_data)
    );

endmodule

/* verilog/img_mem_bank.sv */
`timescale 1ns/100ps
`include "img_params.svh"

module img_mem_bank #(
    parameter int ADDR_W = `SRAM_ADDR_W
) (
    input  logic              i_clk,
    input  logic              i_en,       // access this cycle
    input  logic              i_we,       // 1 write, 0 read
    input  logic [ADDR_W-1:0] i_addr,
    input  img_pkg::pixel_t   i_wdata,
    output img_pkg::pixel_t   o_rdata     // valid one cycle after a read
);
    import img_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    pixel_t mem [DEPTH];   // behavioural stand-in for the 512x8 macro

    // --------------------
    // single port, write or read per cycle
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];   // registered read, no write-through
            end
        end
    end

endmodule

/* verilog/img_params.svh */
`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

// --------------------
// image geometry
// --------------------
`define IMG_W        8                              // pixels per row
`define IMG_H        8                              // rows per channel
`define IMG_C        32                             // channels per image
`define IMG_PIX      (`IMG_W * `IMG_H * `IMG_C)     // 2048 pixels per load

// --------------------
// data widths
// --------------------
`define PIX_W        8                              // unsigned input pixel
`define OUT_W        14                             // output word, zero-extended pixel

// --------------------
// on-chip memory and view limits
// --------------------
`define SRAM_COUNT   4                              // banks, interleaved by channel
`define SRAM_ADDR_W  9                              // 512 words per bank
`define ORG_MAX      6                              // keeps the 2x2 window inside 8x8

`endif

/* verilog/img_pkg.sv */
`include "img_params.svh"

package img_pkg;

    // payload words
    typedef logic        [`PIX_W-1:0] pixel_t;
    typedef logic signed [`OUT_W-1:0] result_t;

    // raster coordinates, index is {chan, y, x}
    typedef logic [$clog2(`IMG_W)-1:0]   coord_t;
    typedef logic [$clog2(`IMG_C)-1:0]   chan_t;
    typedef logic [$clog2(`IMG_PIX)-1:0] pix_index_t;

    // bank split of a raster index
    typedef logic [$clog2(`SRAM_COUNT)-1:0] bank_sel_t;
    typedef logic [`SRAM_ADDR_W-1:0]        bank_addr_t;

    // external opcodes, 8..15 are taken as no-ops
    typedef enum logic [3:0] {
        OP_LOAD    = 4'd0,
        OP_ORG_R   = 4'd1,
        OP_ORG_L   = 4'd2,
        OP_ORG_U   = 4'd3,
        OP_ORG_D   = 4'd4,
        OP_SCALE_D = 4'd5,
        OP_SCALE_U = 4'd6,
        OP_DISPLAY = 4'd7
    } op_mode_t;

    typedef enum logic [1:0] {DEPTH_8, DEPTH_16, DEPTH_32} depth_sel_t;

    // one-cycle strobe from sequencer to config regs
    typedef enum logic [2:0] {
        CFG_NONE, CFG_ORG_R, CFG_ORG_L, CFG_ORG_U, CFG_ORG_D, CFG_DEPTH_D, CFG_DEPTH_U
    } cfg_cmd_t;

endpackage

/* verilog/op_sequencer.sv */
`timescale 1ns/100ps
`include "img_params.svh"

module op_sequencer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_op_valid,   // one-cycle op pulse
    input  img_pkg::op_mode_t   i_op_mode,
    input  logic                i_in_valid,
    input  logic                i_disp_done,  // streamer finished
    output logic                o_op_ready,
    output logic                o_in_ready,
    output logic                o_wr_en,
    output img_pkg::pix_index_t o_wr_index,
    output img_pkg::cfg_cmd_t   o_cfg_cmd,
    output logic                o_disp_start
);
    import img_pkg::*;

    typedef enum logic [2:0] {
        S_BOOT0,    // first cycle out of reset
        S_BOOT1,
        S_WAIT,     // idle, take next op
        S_LOAD,     // 2048 pixels in
        S_CFG,      // config strobe in flight
        S_DISP      // streamer running
    } state_t;

    localparam pix_index_t LAST_PIX = pix_index_t'(`IMG_PIX - 1);

    state_t     state;
    logic       rdy_q;        // registered ready pulse
    pix_index_t load_cnt;     // also the write index

    // opcode -> config command, everything else is CFG_NONE
    function automatic cfg_cmd_t decode_cfg(input op_mode_t op);
        case (op)
            OP_ORG_R:   return CFG_ORG_R;
            OP_ORG_L:   return CFG_ORG_L;
            OP_ORG_U:   return CFG_ORG_U;
            OP_ORG_D:   return CFG_ORG_D;
            OP_SCALE_D: return CFG_DEPTH_D;
            OP_SCALE_U: return CFG_DEPTH_U;
            default:    return CFG_NONE;
        endcase
    endfunction

    // --------------------
    // main FSM
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_BOOT0;
            rdy_q        <= 1'b0;
            o_in_ready   <= 1'b0;
            load_cnt     <= '0;
            o_cfg_cmd    <= CFG_NONE;
            o_disp_start <= 1'b0;
        end else begin
            rdy_q        <= 1'b0;                 // pulses by default
            o_cfg_cmd    <= CFG_NONE;
            o_disp_start <= 1'b0;
            case (state)
                S_BOOT0: state <= S_BOOT1;
                S_BOOT1: begin
                    rdy_q <= 1'b1;                // first ready after reset
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (i_op_valid) begin
                        if (i_op_mode == OP_LOAD) begin
                            load_cnt   <= '0;
                            o_in_ready <= 1'b1;
                            state      <= S_LOAD;
                        end else if (i_op_mode == OP_DISPLAY) begin
                            o_disp_start <= 1'b1;
                            state        <= S_DISP;
                        end else begin
                            o_cfg_cmd <= decode_cfg(i_op_mode);   // no-ops ride along
                            state     <= S_CFG;
                        end
                    end
                end
                S_LOAD: begin
                    if (i_in_valid) begin
                        load_cnt <= load_cnt + 1'b1;
                        if (load_cnt == LAST_PIX) begin
                            o_in_ready <= 1'b0;
                            rdy_q      <= 1'b1;
                            state      <= S_WAIT;
                        end
                    end
                end
                S_CFG: begin
                    rdy_q <= 1'b1;                // regs update on this same edge
                    state <= S_WAIT;
                end
                S_DISP: begin
                    if (i_disp_done) state <= S_WAIT;
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    // display ends on the done cycle itself, no extra register stage
    assign o_op_ready = rdy_q || (state == S_DISP && i_disp_done);
    assign o_wr_en    = (state == S_LOAD) && i_in_valid;
    assign o_wr_index = load_cnt;

endmodule

/* verilog/view_config_regs.sv */
`timescale 1ns/100ps
`include "img_params.svh"

module view_config_regs (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  img_pkg::cfg_cmd_t   i_cfg_cmd,    // one-cycle strobe
    output img_pkg::coord_t     o_origin_x,
    output img_pkg::coord_t     o_origin_y,
    output img_pkg::depth_sel_t o_depth_sel
);
    import img_pkg::*;

    localparam coord_t ORG_LIM = coord_t'(`ORG_MAX);

    // --------------------
    // saturating steps
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_origin_x  <= '0;
            o_origin_y  <= '0;
            o_depth_sel <= DEPTH_32;          // full depth out of reset
        end else begin
            case (i_cfg_cmd)
                CFG_ORG_R: begin
                    if (o_origin_x < ORG_LIM) o_origin_x <= o_origin_x + 3'd1;
                end
                CFG_ORG_L: begin
                    if (o_origin_x != '0) o_origin_x <= o_origin_x - 3'd1;
                end
                CFG_ORG_U: begin
                    if (o_origin_y != '0) o_origin_y <= o_origin_y - 3'd1;   // up is toward row 0
                end
                CFG_ORG_D: begin
                    if (o_origin_y < ORG_LIM) o_origin_y <= o_origin_y + 3'd1;
                end
                CFG_DEPTH_D: begin
                    case (o_depth_sel)
                        DEPTH_32: o_depth_sel <= DEPTH_16;
                        default:  o_depth_sel <= DEPTH_8;  // 16 -> 8, 8 stays
                    endcase
                end
                CFG_DEPTH_U: begin
                    case (o_depth_sel)
                        DEPTH_8:  o_depth_sel <= DEPTH_16;
                        default:  o_depth_sel <= DEPTH_32; // 16 -> 32, 32 stays
                    endcase
                end
                default: ;                            // CFG_NONE, hold
            endcase
        end
    end

endmodule
